//--- verilog.f
logic/gpio_pkg.sv
logic/gpio_bus_if.sv
logic/gpio_apb_ctrl.sv
logic/gpio_in_sync.sv
logic/gpio_irq.sv
logic/gpio_pin_regs.sv
logic/gpio_top.sv
verif/tb_gpio_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the GPIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_gpio_top -f verilog.f
if [ $? -ne 0 ]; then
   echo "verilator compile step returned an error"
   exit 1
fi

out=$(./obj_dir/Vtb_gpio_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
exit 1

//--- verif/tb_gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gpio_top;

   localparam logic [31:0] lfsr_taps = 32'h8020_0003;
   // twice the cycles of reset, all APB accesses and all waits
   localparam int reset_cycles    = 10;
   localparam int apb_ops         = 58;
   localparam int wait_cycles     = 60;
   localparam int watchdog_cycles = 2 * (reset_cycles + 3 * apb_ops + wait_cycles);

   logic                PCLK = 1'b0;
   logic                aresetn;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [7:0]          paddr;
   logic [31:0]         pwdata;
   logic [31:0]         prdata;
   logic                pready;
   logic                pslverr;
   gpio_pkg::pin_vec_t  gpio_in;
   gpio_pkg::pin_vec_t  gpio_out;
   gpio_pkg::pin_vec_t  gpio_oe;
   gpio_pkg::pin_vec_t  int_vec;
   logic                int_or;

   logic [31:0]         lfsr_state = 32'd7;
   logic [7:0]          exp_cfg [gpio_pkg::gpio_num];
   gpio_pkg::pin_vec_t  exp_gpout;
   gpio_pkg::pin_vec_t  exp_int;
   gpio_pkg::pin_vec_t  prev_int;
   logic [31:0]         word;
   int                  checks = 0;
   int                  errors = 0;

   always #5 PCLK = ~PCLK;

   gpio_top u_dut (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .paddr_i    (paddr),
      .pwdata_i   (pwdata),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr),
      .gpio_in_i  (gpio_in),
      .gpio_out_o (gpio_out),
      .gpio_oe_o  (gpio_oe),
      .int_o      (int_vec),
      .int_or_o   (int_or)
   );

   // ------------------------------
   // helpers
   // ------------------------------
   // galois lfsr stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int b = 0; b < n; b++)
      begin
         val = {val[30:0], lfsr_state[0]};
         if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ lfsr_taps;
         else
            lfsr_state = lfsr_state >> 1;
      end
      return val;
   endfunction

   // config byte with int_type on top and out_en in bit 0
   function automatic logic [7:0] cfg_byte(input logic [2:0] itype, input logic ien,
                                           input logic oe, input logic ine, input logic oute);
      return {itype, 1'b0, ien, oe, ine, oute};
   endfunction

   // one config bit of every pin gathered into a vector
   function automatic gpio_pkg::pin_vec_t field_vec(input int pos);
      gpio_pkg::pin_vec_t v;
      for (int i = 0; i < gpio_pkg::gpio_num; i++)
         v[i] = exp_cfg[i][pos];
      return v;
   endfunction

   // expected INT when only level types are in use
   function automatic gpio_pkg::pin_vec_t level_model(input gpio_pkg::pin_vec_t in_v);
      gpio_pkg::pin_vec_t r;
      for (int i = 0; i < gpio_pkg::gpio_num; i++)
      begin
         case (exp_cfg[i][7:5])
            3'd0:    r[i] = in_v[i];
            3'd1:    r[i] = ~in_v[i];
            default: r[i] = 1'b0;
         endcase
         r[i] = r[i] & exp_cfg[i][3];
      end
      return r;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      @(negedge PCLK);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge PCLK);
      penable = 1'b1;
      @(negedge PCLK);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // prdata checked in the access phase while paddr is held
   task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
      @(negedge PCLK);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge PCLK);
      penable = 1'b1;
      check_value($sformatf("prdata_o[0x%02h]", addr), prdata, exp);
      @(negedge PCLK);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_pins(input gpio_pkg::pin_vec_t exp);
      check_value("int_o", 32'(int_vec), 32'(exp));
      check_value("int_or_o", 32'(int_or), 32'(|exp));
   endtask

   // ------------------------------
   // watchdog
   // ------------------------------
   initial
   begin
      #(watchdog_cycles * 10);
      $display("watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
      $display("*** FAILED ***");
      $finish;
   end

   // ------------------------------
   // main sequence
   // ------------------------------
   initial
   begin
      aresetn = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      gpio_in = '0;
      repeat (reset_cycles) @(posedge PCLK);
      @(negedge PCLK);
      aresetn = 1'b1;

      // reset state
      check_value("gpio_out_o", 32'(gpio_out), 32'h0);
      check_value("gpio_oe_o", 32'(gpio_oe), 32'h0);
      check_pins('0);
      check_value("pready_o", 32'(pready), 32'h1);
      check_value("pslverr_o", 32'(pslverr), 32'h0);
      read_check(gpio_pkg::addr_gpout, 32'hA5);

      // random config bytes read back
      for (int i = 0; i < gpio_pkg::gpio_num; i++)
      begin
         word       = rand_bits(32);
         exp_cfg[i] = word[7:0];
         write_reg(8'(4 * i), word);
      end
      for (int i = 0; i < gpio_pkg::gpio_num; i++)
         read_check(8'(4 * i), 32'(exp_cfg[i]));

      word      = rand_bits(32);
      exp_gpout = word[7:0];
      write_reg(gpio_pkg::addr_gpout, word);
      check_value("gpio_out_o", 32'(gpio_out), 32'(exp_gpout & field_vec(0)));
      check_value("gpio_oe_o", 32'(gpio_oe), 32'(field_vec(2) & field_vec(0)));
      read_check(gpio_pkg::addr_gpout, 32'(exp_gpout));
      read_check(8'(4 * gpio_pkg::gpio_num), 32'h0);
      read_check(8'h7C, 32'h0);
      read_check(8'h84, 32'h0);
      read_check(8'hFC, 32'h0);

      // input read-back
      for (int k = 0; k < 4; k++)
      begin
         @(negedge PCLK);
         gpio_in = 8'(rand_bits(8));
         repeat (3) @(posedge PCLK);
         read_check(gpio_pkg::addr_gpin, 32'(gpio_in & field_vec(1)));
      end

      // ------------------------------
      // level interrupts
      // ------------------------------
      for (int i = 0; i < gpio_pkg::gpio_num; i++)
      begin
         if (i < 3)
            exp_cfg[i] = cfg_byte(3'd0, 1'b1, 1'b0, 1'b1, 1'b0);
         else if (i < 6)
            exp_cfg[i] = cfg_byte(3'd1, 1'b1, 1'b0, 1'b1, 1'b0);
         else if (i == 6)
            exp_cfg[i] = cfg_byte(3'd0, 1'b0, 1'b0, 1'b1, 1'b0);
         else
            exp_cfg[i] = cfg_byte(3'd7, 1'b1, 1'b0, 1'b1, 1'b0);
         write_reg(8'(4 * i), 32'(exp_cfg[i]));
      end
      for (int k = 0; k < 6; k++)
      begin
         prev_int = level_model(gpio_in);
         @(negedge PCLK);
         gpio_in = 8'(rand_bits(8));
         exp_int = level_model(gpio_in);
         repeat (2) @(posedge PCLK);
         @(negedge PCLK);
         check_pins(prev_int);
         @(negedge PCLK);
         check_pins(exp_int);
         read_check(gpio_pkg::addr_intr, 32'(exp_int));
      end

      // ------------------------------
      // edge interrupts
      // ------------------------------
      // int_en low empties the latches first
      for (int i = 0; i < gpio_pkg::gpio_num; i++)
      begin
         exp_cfg[i] = '0;
         write_reg(8'(4 * i), 32'h0);
      end
      @(negedge PCLK);
      gpio_in = '0;
      repeat (4) @(posedge PCLK);
      write_reg(8'h00, 32'(cfg_byte(3'd2, 1'b1, 1'b0, 1'b1, 1'b0)));
      write_reg(8'h04, 32'(cfg_byte(3'd3, 1'b1, 1'b0, 1'b1, 1'b0)));
      write_reg(8'h08, 32'(cfg_byte(3'd4, 1'b1, 1'b0, 1'b1, 1'b0)));
      write_reg(gpio_pkg::addr_intr, 32'hFF);
      check_pins('0);

      // rise on pins 0 and 2
      @(negedge PCLK);
      gpio_in = 8'b0000_0101;
      repeat (2) @(posedge PCLK);
      @(negedge PCLK);
      check_pins('0);
      @(negedge PCLK);
      check_pins(8'b0000_0101);

      // pins 0 and 2 fall back while pin 1 rises against its edge type
      @(negedge PCLK);
      gpio_in = 8'b0000_0010;
      repeat (4) @(posedge PCLK);
      @(negedge PCLK);
      check_pins(8'b0000_0101);

      // pin 1 falls
      @(negedge PCLK);
      gpio_in = '0;
      repeat (3) @(posedge PCLK);
      @(negedge PCLK);
      check_pins(8'b0000_0111);
      read_check(gpio_pkg::addr_intr, 32'h07);

      write_reg(gpio_pkg::addr_intr, 32'h01);
      check_pins(8'b0000_0110);
      read_check(gpio_pkg::addr_intr, 32'h06);
      write_reg(gpio_pkg::addr_intr, 32'h06);
      check_pins('0);
      read_check(gpio_pkg::addr_intr, 32'h00);

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_top (
   input  wire                           PCLK,
   input  wire                           aresetn,
   input  wire                           psel_i,
   input  wire                           penable_i,
   input  wire                           pwrite_i,
   input  wire  [gpio_pkg::apb_aw-1:0]   paddr_i,
   input  wire  [gpio_pkg::apb_dw-1:0]   pwdata_i,
   output logic [gpio_pkg::apb_dw-1:0]   prdata_o,
   output logic                          pready_o,
   output logic                          pslverr_o,
   input  gpio_pkg::pin_vec_t            gpio_in_i,
   output gpio_pkg::pin_vec_t            gpio_out_o,
   output gpio_pkg::pin_vec_t            gpio_oe_o,
   output gpio_pkg::pin_vec_t            int_o,
   output logic                          int_or_o
);

   gpio_pkg::pin_vec_t                          lvl;
   gpio_pkg::pin_vec_t                          rise;
   gpio_pkg::pin_vec_t                          fall;
   gpio_pkg::pin_cfg_t [gpio_pkg::gpio_num-1:0] cfg;
   gpio_pkg::pin_vec_t                          gpin_rd;
   gpio_pkg::pin_vec_t                          gpout;
   gpio_pkg::pin_vec_t                          intr_reg;

   // zero wait states, no error responses
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   gpio_bus_if u_bus ();

   // ------------------------------
   // APB decode and read mux
   // ------------------------------
   gpio_apb_ctrl u_ctrl (
      .PCLK      (PCLK),
      .aresetn   (aresetn),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .cfg_i     (cfg),
      .gpin_i    (gpin_rd),
      .gpout_i   (gpout),
      .intr_i    (intr_reg),
      .prdata_o  (prdata_o),
      .bus       (u_bus.ctrl)
   );

   gpio_in_sync u_sync (
      .PCLK      (PCLK),
      .aresetn   (aresetn),
      .gpio_in_i (gpio_in_i),
      .lvl_o     (lvl),
      .rise_o    (rise),
      .fall_o    (fall)
   );

   gpio_pin_regs u_regs (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .lvl_i      (lvl),
      .bus        (u_bus.regs),
      .cfg_o      (cfg),
      .gpin_o     (gpin_rd),
      .gpout_o    (gpout),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o)
   );

   gpio_irq u_irq (
      .PCLK     (PCLK),
      .aresetn  (aresetn),
      .lvl_i    (lvl),
      .rise_i   (rise),
      .fall_i   (fall),
      .cfg_i    (cfg),
      .bus      (u_bus.irq),
      .int_o    (int_o),
      .int_or_o (int_or_o),
      .intr_o   (intr_reg)
   );

endmodule

`default_nettype wire

//--- logic/gpio_pin_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_pin_regs (
   input  wire                                       PCLK,
   input  wire                                       aresetn,
   input  gpio_pkg::pin_vec_t                        lvl_i,
   gpio_bus_if.regs                                  bus,
   output gpio_pkg::pin_cfg_t [gpio_pkg::gpio_num-1:0] cfg_o,
   output gpio_pkg::pin_vec_t                        gpin_o,
   output gpio_pkg::pin_vec_t                        gpout_o,
   output gpio_pkg::pin_vec_t                        gpio_out_o,
   output gpio_pkg::pin_vec_t                        gpio_oe_o
);

   gpio_pkg::pin_cfg_t [gpio_pkg::gpio_num-1:0] cfg_q;
   gpio_pkg::pin_vec_t                          gpout_q;
   gpio_pkg::pin_vec_t                          out_en;
   gpio_pkg::pin_vec_t                          oe_en;
   gpio_pkg::pin_vec_t                          in_en;

   // ------------------------------
   // configuration bytes
   // ------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         cfg_q <= '0;
      else if (bus.cfg_we)
         cfg_q[bus.cfg_idx] <= bus.wdata.cfg.pin;
   end

   // output data, comes up with the package reset pattern
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         gpout_q <= gpio_pkg::gpout_reset_val;
      else if (bus.gpout_we)
         gpout_q <= bus.wdata.pins.mask;
   end

   // gather enable bits into per-pin vectors
   always_comb
   begin
      for (int i = 0; i < gpio_pkg::gpio_num; i++)
      begin
         out_en[i] = cfg_q[i].out_en;
         oe_en[i]  = cfg_q[i].oe_en;
         in_en[i]  = cfg_q[i].in_en;
      end
   end

   // ------------------------------
   // pin gating
   // ------------------------------
   assign gpio_out_o = gpout_q & out_en;
   // driver enable only for pins configured as outputs
   assign gpio_oe_o  = oe_en & out_en;
   assign gpin_o     = lvl_i & in_en;

   assign cfg_o   = cfg_q;
   assign gpout_o = gpout_q;

endmodule

`default_nettype wire

//--- logic/gpio_irq.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_irq (
   input  wire                                      PCLK,
   input  wire                                      aresetn,
   input  gpio_pkg::pin_vec_t                       lvl_i,
   input  gpio_pkg::pin_vec_t                       rise_i,
   input  gpio_pkg::pin_vec_t                       fall_i,
   input  gpio_pkg::pin_cfg_t [gpio_pkg::gpio_num-1:0] cfg_i,
   gpio_bus_if.irq                                  bus,
   output gpio_pkg::pin_vec_t                       int_o,
   output logic                                     int_or_o,
   output gpio_pkg::pin_vec_t                       intr_o
);

   gpio_pkg::pin_vec_t int_en;
   gpio_pkg::pin_vec_t clr_mask;
   gpio_pkg::pin_vec_t pos_q;
   gpio_pkg::pin_vec_t neg_q;
   gpio_pkg::pin_vec_t both_q;
   gpio_pkg::pin_vec_t int_live;
   gpio_pkg::pin_vec_t intr_q;

   // set wins over a clear in the same cycle, int_en low holds the latch at 0
   function automatic gpio_pkg::pin_vec_t latch_next(
      input gpio_pkg::pin_vec_t q,
      input gpio_pkg::pin_vec_t set,
      input gpio_pkg::pin_vec_t clr,
      input gpio_pkg::pin_vec_t en
   );
      return en & (set | (q & ~clr));
   endfunction

   assign clr_mask = bus.intr_clr_we ? bus.wdata.pins.mask : '0;

   // ------------------------------
   // sticky edge latches
   // ------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         pos_q  <= '0;
         neg_q  <= '0;
         both_q <= '0;
      end
      else
      begin
         pos_q  <= latch_next(pos_q, rise_i, clr_mask, int_en);
         neg_q  <= latch_next(neg_q, fall_i, clr_mask, int_en);
         both_q <= latch_next(both_q, rise_i | fall_i, clr_mask, int_en);
      end
   end

   // ------------------------------
   // per-pin interrupt select
   // ------------------------------
   always_comb
   begin
      for (int i = 0; i < gpio_pkg::gpio_num; i++)
      begin
         int_en[i] = cfg_i[i].int_en;
         case (cfg_i[i].int_type)
            gpio_pkg::level_high: int_live[i] = lvl_i[i];
            gpio_pkg::level_low:  int_live[i] = ~lvl_i[i];
            gpio_pkg::edge_pos:   int_live[i] = pos_q[i];
            gpio_pkg::edge_neg:   int_live[i] = neg_q[i];
            gpio_pkg::edge_both:  int_live[i] = both_q[i];
            gpio_pkg::int_off:    int_live[i] = 1'b0;
            default:              int_live[i] = 1'b0;
         endcase
         int_live[i] = int_live[i] & cfg_i[i].int_en;
      end
   end

   assign int_o    = int_live;
   assign int_or_o = |int_live;

   // ------------------------------
   // interrupt register
   // ------------------------------
   // tracks live interrupts, a clear write masks the held value instead
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         intr_q <= '0;
      else if (bus.intr_clr_we)
         intr_q <= intr_q & ~bus.wdata.pins.mask;
      else
         intr_q <= int_live;
   end

   assign intr_o = intr_q;

endmodule

`default_nettype wire

//--- logic/gpio_in_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_in_sync (
   input  wire                 PCLK,
   input  wire                 aresetn,
   input  gpio_pkg::pin_vec_t  gpio_in_i,
   output gpio_pkg::pin_vec_t  lvl_o,
   output gpio_pkg::pin_vec_t  rise_o,
   output gpio_pkg::pin_vec_t  fall_o
);

   gpio_pkg::pin_vec_t sync1_q;
   gpio_pkg::pin_vec_t sync2_q;
   gpio_pkg::pin_vec_t hist_q;

   // ------------------------------
   // two-flop synchronizer
   // ------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         sync1_q <= '0;
         sync2_q <= '0;
      end
      else
      begin
         sync1_q <= gpio_in_i;
         sync2_q <= sync1_q;
      end
   end

   // history stage, one cycle behind the synchronizer
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         hist_q <= '0;
      else
         hist_q <= sync2_q;
   end

   assign lvl_o  = hist_q;
   // edge seen between sync output and history
   assign rise_o = sync2_q & ~hist_q;
   assign fall_o = ~sync2_q & hist_q;

endmodule

`default_nettype wire

//--- logic/gpio_apb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_apb_ctrl (
   input  wire                                      PCLK,
   input  wire                                      aresetn,
   input  wire                                      psel_i,
   input  wire                                      penable_i,
   input  wire                                      pwrite_i,
   input  wire  [gpio_pkg::apb_aw-1:0]              paddr_i,
   input  wire  [gpio_pkg::apb_dw-1:0]              pwdata_i,
   input  gpio_pkg::pin_cfg_t [gpio_pkg::gpio_num-1:0] cfg_i,
   input  gpio_pkg::pin_vec_t                       gpin_i,
   input  gpio_pkg::pin_vec_t                       gpout_i,
   input  gpio_pkg::pin_vec_t                       intr_i,
   output logic [gpio_pkg::apb_dw-1:0]              prdata_o,
   gpio_bus_if.ctrl                                 bus
);

   logic                              setup_q;
   logic                              wr_acc;
   logic [gpio_pkg::apb_aw-3:0]       pin_sel;
   logic                              cfg_win;
   logic                              cfg_hit;
   gpio_pkg::pin_idx_t                pin_idx;
   logic [7:0]                        cfg_byte;

   // ------------------------------
   // access phase tracking
   // ------------------------------
   // an access phase always follows a setup phase, PREADY is always high
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         setup_q <= 1'b0;
      else
         setup_q <= psel_i & ~penable_i;
   end

   assign wr_acc = psel_i & penable_i & pwrite_i & setup_q;

   // ------------------------------
   // address decode
   // ------------------------------
   assign pin_sel = paddr_i[gpio_pkg::apb_aw-1:2];
   assign pin_idx = paddr_i[2 +: gpio_pkg::idx_w];
   assign cfg_win = paddr_i < gpio_pkg::cfg_span;
   // word index past the last pin reads as zero and ignores writes
   assign cfg_hit = cfg_win && (pin_sel < (gpio_pkg::apb_aw-2)'(gpio_pkg::gpio_num));

   assign bus.cfg_we      = wr_acc & cfg_hit;
   assign bus.cfg_idx     = pin_idx;
   assign bus.intr_clr_we = wr_acc & (paddr_i == gpio_pkg::addr_intr);
   assign bus.gpout_we    = wr_acc & (paddr_i == gpio_pkg::addr_gpout);
   assign bus.wdata       = gpio_pkg::apb_wdata_u'(pwdata_i);

   // ------------------------------
   // read mux
   // ------------------------------
   assign cfg_byte = cfg_i[pin_idx];

   always_comb
   begin
      prdata_o = '0;
      if (cfg_win)
      begin
         if (cfg_hit)
            prdata_o = gpio_pkg::apb_dw'(cfg_byte);
      end
      else
      begin
         case (paddr_i)
            gpio_pkg::addr_intr:  prdata_o = gpio_pkg::apb_dw'(intr_i);
            gpio_pkg::addr_gpin:  prdata_o = gpio_pkg::apb_dw'(gpin_i);
            gpio_pkg::addr_gpout: prdata_o = gpio_pkg::apb_dw'(gpout_i);
            default:              prdata_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/gpio_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface gpio_bus_if;

   // strobes are single-cycle, valid in the APB access phase
   logic                   cfg_we;
   gpio_pkg::pin_idx_t     cfg_idx;
   logic                   intr_clr_we;
   logic                   gpout_we;
   gpio_pkg::apb_wdata_u   wdata;

   modport ctrl (
      output cfg_we,
      output cfg_idx,
      output intr_clr_we,
      output gpout_we,
      output wdata
   );

   modport regs (
      input cfg_we,
      input cfg_idx,
      input gpout_we,
      input wdata
   );

   modport irq (
      input intr_clr_we,
      input wdata
   );

endinterface

`default_nettype wire

//--- logic/gpio_pkg.sv
`default_nettype none

package gpio_pkg;

   // ------------------------------
   // sizes
   // ------------------------------
   localparam int unsigned gpio_num = 8;
   localparam int unsigned apb_dw   = 32;
   localparam int unsigned apb_aw   = 8;
   localparam int unsigned idx_w    = $clog2(gpio_num);

   // ------------------------------
   // address map
   // ------------------------------
   localparam logic [apb_aw-1:0] addr_intr  = 8'h80;
   localparam logic [apb_aw-1:0] addr_gpin  = 8'h90;
   localparam logic [apb_aw-1:0] addr_gpout = 8'hA0;
   // config bytes, one word per pin, start at 0
   localparam logic [apb_aw-1:0] cfg_span   = addr_intr;

   typedef logic [gpio_num-1:0] pin_vec_t;
   typedef logic [idx_w-1:0]    pin_idx_t;

   localparam pin_vec_t gpout_reset_val = 8'hA5;

   // codes 5 and 6 also mean no interrupt
   typedef enum logic [2:0] {
      level_high = 3'd0,
      level_low  = 3'd1,
      edge_pos   = 3'd2,
      edge_neg   = 3'd3,
      edge_both  = 3'd4,
      int_off    = 3'd7
   } int_type_t;

   typedef struct packed {
      int_type_t int_type;
      logic      spare;
      logic      int_en;
      logic      oe_en;
      logic      in_en;
      logic      out_en;
   } pin_cfg_t;

   // write word seen as a config byte
   typedef struct packed {
      logic [apb_dw-$bits(pin_cfg_t)-1:0] pad;
      pin_cfg_t                           pin;
   } cfg_word_t;

   // write word seen as one bit per pin
   typedef struct packed {
      logic [apb_dw-gpio_num-1:0] pad;
      pin_vec_t                   mask;
   } pins_word_t;

   typedef union packed {
      cfg_word_t  cfg;
      pins_word_t pins;
   } apb_wdata_u;

endpackage

`default_nettype wire
